// ==== Bender.yml ====
package:
  name: pc_to_inst_mem

sources:
  - include_dirs:
      - source
    files:
      - source/loader_pkg.sv
      - source/baud_tick_gen.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/word_assembler.sv
      - source/fetch_unit.sv
      - source/top_pc_to_inst_mem.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_top.sv

// ==== project.f ====
+incdir+source
source/loader_pkg.sv
source/baud_tick_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/word_assembler.sv
source/fetch_unit.sv
source/top_pc_to_inst_mem.sv
sim/tb_top.sv

// ==== sim/tb_top.sv ====
// testbench: random program load over uart loopback, memory and fetch model, watchdog
`default_nettype none

`include "loader_defines.svh"

module tb_top
	import loader_pkg::*;
();

	logic clock_i;
	logic rst_i;
	logic tx_start_i;
	logic fetch_en_i;
	logic jump_i;
	byte_t tx_din_i;
	iaddr_t jump_addr_i;
	logic serial_o;
	logic tx_ready_o;
	logic tx_done_o;
	logic rx_done_o;
	logic load_done_o;
	byte_t rx_byte_o;
	rx_state_e rx_state_o;
	iaddr_t pc_o;
	word_t instr_o;

	integer seed = 32'ha78eaed6;
	int n_words = 0;
	int prog_bytes = 0;
	int sent_count = 0;
	int rx_count = 0;
	int tx_done_count = 0;
	int check_count = 0;
	int error_count = 0;
	logic monitor_on = 1'b0;
	byte_t sent_q [$];
	word_t exp_mem [`LDR_IMEM_DEPTH];
	iaddr_t mdl_pc = '0;
	iaddr_t exp_pc_o = '0;
	word_t exp_instr = '0;

	top_pc_to_inst_mem top_pc_to_inst_mem_i (.*);

	initial clock_i = 1'b0;
	always #10 clock_i = ~clock_i;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		assert (act === exp) else begin
			error_count++;
			$display("[FAIL] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic flag_error(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

	// one byte through the transmitter and a start pulse while it is busy
	task automatic send_byte(input byte_t b);
		int gap;
		while (!tx_ready_o)
			@(negedge clock_i);
		tx_start_i = 1'b1;
		tx_din_i = b;
		sent_q.push_back(b);
		sent_count++;
		@(negedge clock_i);
		tx_start_i = 1'b0;
		gap = 1 + ($unsigned($random(seed)) % 64);
		repeat (gap)
			@(negedge clock_i);
		tx_start_i = 1'b1;
		tx_din_i = ~b;
		@(negedge clock_i);
		tx_start_i = 1'b0;
	endtask

	// drive one fetch cycle and check pc_o and instr_o against the model
	task automatic fetch_step(input logic en, input logic jmp, input iaddr_t addr);
		fetch_en_i = en;
		jump_i = jmp;
		jump_addr_i = addr;
		@(negedge clock_i);
		if (en) begin
			exp_pc_o = mdl_pc;
			exp_instr = exp_mem[mdl_pc];
			if (jmp)
				mdl_pc = addr;
			else if (mdl_pc == iaddr_t'(`LDR_IMEM_DEPTH - 1))
				mdl_pc = '0;
			else
				mdl_pc = mdl_pc + 1'b1;
		end
		compare("pc_o", 32'(exp_pc_o), 32'(pc_o));
		compare("instr_o", exp_instr, instr_o);
	endtask

	// receiver and load flag monitor on the falling edge
	always @(negedge clock_i) begin
		if (monitor_on) begin
			compare("load_done_o", 32'(rx_count >= prog_bytes), 32'(load_done_o));
			if (tx_done_o) begin
				tx_done_count++;
				// ready comes back with the done strobe
				compare("tx_ready_o", 32'd1, 32'(tx_ready_o));
			end
			if (rx_done_o) begin
				check_count++;
				assert (sent_q.size() > 0) else
					flag_error("receiver strobed with no byte outstanding");
				if (sent_q.size() > 0)
					compare("rx_byte_o", 32'(sent_q.pop_front()), 32'(rx_byte_o));
				// receiver waits for the next start bit
				compare("rx_state_o", 32'(RX_IDLE), 32'(rx_state_o));
				rx_count++;
			end
		end
	end

	initial begin
		wait (n_words != 0);
		repeat ((n_words + 2) * 4 * 1440 + 2000)
			@(posedge clock_i);
		error_count++;
		$display("watchdog expired before the test finished");
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		word_t w;
		word_t prog [$];
		rst_i = 1'b1;
		tx_start_i = 1'b0;
		tx_din_i = '0;
		fetch_en_i = 1'b0;
		jump_i = 1'b0;
		jump_addr_i = '0;
		for (int i = 0; i < `LDR_IMEM_DEPTH; i++)
			exp_mem[i] = '0;
		n_words = 8 + ($unsigned($random(seed)) % 13);
		prog_bytes = 4 * (n_words + 1);
		for (int i = 0; i < n_words; i++) begin
			do
				w = $random(seed);
			while (w == `LDR_HALT_WORD);
			prog.push_back(w);
		end
		prog.push_back(`LDR_HALT_WORD);
		foreach (prog[i])
			exp_mem[i] = prog[i];

		repeat (4)
			@(negedge clock_i);
		compare("tx_ready_o", 32'd1, 32'(tx_ready_o));
		compare("serial_o", 32'd1, 32'(serial_o));
		compare("load_done_o", 32'd0, 32'(load_done_o));
		compare("pc_o", 32'd0, 32'(pc_o));
		compare("instr_o", 32'd0, instr_o);
		compare("rx_state_o", 32'(RX_IDLE), 32'(rx_state_o));
		rst_i = 1'b0;
		monitor_on = 1'b1;

		// most significant byte first
		foreach (prog[i])
			for (int k = 3; k >= 0; k--)
				send_byte(prog[i][8*k +: 8]);
		// after the halt word these must not reach memory
		repeat (4)
			send_byte(byte_t'($random(seed)));
		while (sent_q.size() != 0)
			@(negedge clock_i);
		while (!tx_ready_o)
			@(negedge clock_i);
		@(negedge clock_i);
		compare("rx_done_o count", sent_count, rx_count);
		compare("tx_done_o count", sent_count, tx_done_count);

		for (int i = 0; i < n_words + 2; i++)
			fetch_step(1'b1, 1'b0, '0);
		repeat (200)
			fetch_step(($random(seed) & 1) != 0, ($random(seed) & 7) == 0,
				iaddr_t'($random(seed)));
		// walk across the top of memory
		fetch_step(1'b1, 1'b1, iaddr_t'(`LDR_IMEM_DEPTH - 4));
		repeat (8)
			fetch_step(1'b1, 1'b0, '0);
		fetch_en_i = 1'b0;

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/baud_tick_gen.sv ====
// baud_tick_gen: clock divider producing the uart oversampling tick
`default_nettype none

`include "loader_defines.svh"

module baud_tick_gen (
	input wire clock_i,
	input wire rst_i,
	output logic tick_o
);

	localparam int unsigned CNT_W = $clog2(`LDR_TICK_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LDR_TICK_DIV - 1);

	logic [CNT_W-1:0] cnt_q;

	// tick is one clock wide, once per divider period
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			cnt_q <= '0;
			tick_o <= 1'b0;
		end else if (cnt_q == CNT_LAST) begin
			cnt_q <= '0;
			tick_o <= 1'b1;
		end else begin
			cnt_q <= cnt_q + 1'b1;
			tick_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
// fetch_unit: instruction memory with load port, program counter and registered fetch
`default_nettype none

`include "loader_defines.svh"

module fetch_unit
	import loader_pkg::*;
(
	input wire clock_i,
	input wire rst_i,
	input wire fetch_en_i,
	input wire jump_i,
	input wire iaddr_t jump_addr_i,
	input wire imem_wr_t wr_i,
	output word_t instr_o,
	output iaddr_t pc_o
);

	word_t mem [`LDR_IMEM_DEPTH];
	iaddr_t pc_q;

	// empty program until the loader fills it
	initial begin
		for (int i = 0; i < `LDR_IMEM_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clock_i) begin
		if (wr_i.en)
			mem[wr_i.addr] <= wr_i.data;
	end

	// read before write on a shared address, pc wraps past the last word
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			pc_q <= '0;
			pc_o <= '0;
			instr_o <= '0;
		end else if (fetch_en_i) begin
			instr_o <= mem[pc_q];
			pc_o <= pc_q;
			pc_q <= jump_i ? jump_addr_i : pc_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/loader_defines.svh ====
// clock, baud, oversampling, instruction memory depth and halt word macros
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// system clock in hz
`define LDR_CLK_HZ 30000000

// serial line rate
`define LDR_BAUD 203400

// ticks per serial bit
`define LDR_OVERSAMPLE 16

// clocks per oversampling tick, 9 at the rates above
`define LDR_TICK_DIV (`LDR_CLK_HZ / (`LDR_BAUD * `LDR_OVERSAMPLE))

// instruction words in memory
`define LDR_IMEM_DEPTH 128

// mips halt pattern, last word of a program
`define LDR_HALT_WORD 32'hFC000000

`endif

// ==== source/loader_pkg.sv ====
// loader types: data widths, uart state enums and instruction memory write struct
`default_nettype none

`include "loader_defines.svh"

package loader_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [$clog2(`LDR_IMEM_DEPTH)-1:0] iaddr_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// one instruction memory write
	typedef struct packed {
		logic en;
		iaddr_t addr;
		word_t data;
	} imem_wr_t;

endpackage

`default_nettype wire

// ==== source/top_pc_to_inst_mem.sv ====
// top_pc_to_inst_mem: uart loopback loader feeding instruction memory and fetch
`default_nettype none

module top_pc_to_inst_mem
	import loader_pkg::*;
(
	input wire clock_i,
	input wire rst_i,
	input wire tx_start_i,
	input wire fetch_en_i,
	input wire jump_i,
	input wire byte_t tx_din_i,
	input wire iaddr_t jump_addr_i,
	output logic serial_o,
	output logic tx_ready_o,
	output logic tx_done_o,
	output logic rx_done_o,
	output logic load_done_o,
	output byte_t rx_byte_o,
	output rx_state_e rx_state_o,
	output iaddr_t pc_o,
	output word_t instr_o
);

	logic tick;
	imem_wr_t imem_wr;

	baud_tick_gen baud_tick_gen_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.tick_o(tick)
	);

	uart_tx uart_tx_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.tick_i(tick),
		.start_i(tx_start_i),
		.din_i(tx_din_i),
		.serial_o(serial_o),
		.ready_o(tx_ready_o),
		.done_o(tx_done_o)
	);

	// serial line loops straight back into the receiver
	uart_rx uart_rx_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.tick_i(tick),
		.serial_i(serial_o),
		.byte_o(rx_byte_o),
		.done_o(rx_done_o),
		.state_o(rx_state_o)
	);

	word_assembler word_assembler_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.byte_valid_i(rx_done_o),
		.byte_i(rx_byte_o),
		.wr_o(imem_wr),
		.load_done_o(load_done_o)
	);

	fetch_unit fetch_unit_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.fetch_en_i(fetch_en_i),
		.jump_i(jump_i),
		.jump_addr_i(jump_addr_i),
		.wr_i(imem_wr),
		.instr_o(instr_o),
		.pc_o(pc_o)
	);

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
// uart_rx: oversampling 8n1 serial receiver
`default_nettype none

`include "loader_defines.svh"

module uart_rx
	import loader_pkg::*;
(
	input wire clock_i,
	input wire rst_i,
	input wire tick_i,
	input wire serial_i,
	output byte_t byte_o,
	output logic done_o,
	output rx_state_e state_o
);

	localparam int unsigned TCNT_W = $clog2(`LDR_OVERSAMPLE);
	localparam logic [TCNT_W-1:0] TCNT_LAST = TCNT_W'(`LDR_OVERSAMPLE - 1);
	localparam logic [TCNT_W-1:0] TCNT_MID = TCNT_W'(`LDR_OVERSAMPLE / 2 - 1);

	rx_state_e state_q;
	logic [TCNT_W-1:0] tick_cnt_q;
	logic [2:0] bit_cnt_q;
	logic sample;

	assign state_o = state_q;
	// middle of a data or stop bit, start bit is centred already
	assign sample = tick_i && (tick_cnt_q == TCNT_LAST);

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q <= RX_IDLE;
			tick_cnt_q <= '0;
			bit_cnt_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (tick_i)
				tick_cnt_q <= tick_cnt_q + 1'b1;
			case (state_q)
				RX_IDLE: begin
					tick_cnt_q <= '0;
					// falling edge starts a frame
					if (!serial_i)
						state_q <= RX_START;
				end
				RX_START: begin
					if (tick_i && tick_cnt_q == TCNT_MID) begin
						tick_cnt_q <= '0;
						bit_cnt_q <= '0;
						// glitch shorter than half a bit goes back to idle
						state_q <= serial_i ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample) begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == 3'd7)
							state_q <= RX_STOP;
					end
				end
				default: begin
					if (sample) begin
						done_o <= 1'b1;
						state_q <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// data arrives lsb first
	always_ff @(posedge clock_i) begin
		if (state_q == RX_DATA && sample)
			byte_o <= {serial_i, byte_o[7:1]};
	end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// uart_tx: 8n1 serial transmitter with ready level and done strobe
`default_nettype none

`include "loader_defines.svh"

module uart_tx
	import loader_pkg::*;
(
	input wire clock_i,
	input wire rst_i,
	input wire tick_i,
	input wire start_i,
	input wire byte_t din_i,
	output logic serial_o,
	output logic ready_o,
	output logic done_o
);

	localparam int unsigned TCNT_W = $clog2(`LDR_OVERSAMPLE);
	localparam logic [TCNT_W-1:0] TCNT_LAST = TCNT_W'(`LDR_OVERSAMPLE - 1);

	tx_state_e state_q;
	logic [TCNT_W-1:0] tick_cnt_q;
	logic [2:0] bit_cnt_q;
	byte_t shreg_q;
	logic bit_end;

	assign bit_end = tick_i && (tick_cnt_q == TCNT_LAST);
	assign ready_o = (state_q == TX_IDLE);

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q <= TX_IDLE;
			tick_cnt_q <= '0;
			bit_cnt_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (tick_i)
				tick_cnt_q <= tick_cnt_q + 1'b1;
			case (state_q)
				TX_IDLE: begin
					tick_cnt_q <= '0;
					if (start_i)
						state_q <= TX_START;
				end
				TX_START: begin
					if (bit_end) begin
						bit_cnt_q <= '0;
						state_q <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == 3'd7)
							state_q <= TX_STOP;
					end
				end
				default: begin
					// end of stop bit, ready rises with done
					if (bit_end) begin
						done_o <= 1'b1;
						state_q <= TX_IDLE;
					end
				end
			endcase
		end
	end

	// byte under transmission, lsb goes out first
	always_ff @(posedge clock_i) begin
		if (state_q == TX_IDLE && start_i)
			shreg_q <= din_i;
		else if (state_q == TX_DATA && bit_end)
			shreg_q <= shreg_q >> 1;
	end

	always_comb begin
		case (state_q)
			TX_START: serial_o = 1'b0;
			TX_DATA: serial_o = shreg_q[0];
			default: serial_o = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/word_assembler.sv ====
// word_assembler: packs received bytes into instruction writes, flags end of load
`default_nettype none

`include "loader_defines.svh"

module word_assembler
	import loader_pkg::*;
(
	input wire clock_i,
	input wire rst_i,
	input wire byte_valid_i,
	input wire byte_t byte_i,
	output imem_wr_t wr_o,
	output logic load_done_o
);

	localparam iaddr_t ADDR_LAST = iaddr_t'(`LDR_IMEM_DEPTH - 1);

	logic [1:0] byte_cnt_q;
	logic wr_en_q;
	iaddr_t addr_q;
	word_t word_q;
	logic done_q;
	logic take;

	// nothing accepted once the program is in
	assign take = byte_valid_i && !load_done_o;

	assign load_done_o = done_q
		|| (wr_en_q && (word_q == `LDR_HALT_WORD || addr_q == ADDR_LAST));

	assign wr_o = '{en: wr_en_q, addr: addr_q, data: word_q};

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			byte_cnt_q <= '0;
			wr_en_q <= 1'b0;
			addr_q <= '0;
			done_q <= 1'b0;
		end else begin
			wr_en_q <= take && (byte_cnt_q == 2'd3);
			if (take)
				byte_cnt_q <= byte_cnt_q + 1'b1;
			if (wr_en_q)
				addr_q <= addr_q + 1'b1;
			done_q <= load_done_o;
		end
	end

	// first byte ends up in the top of the word
	always_ff @(posedge clock_i) begin
		if (take)
			word_q <= {word_q[23:0], byte_i};
	end

endmodule

`default_nettype wire
